//--- Makefile
# Verilator build and run of the SPI master testbench

VERILATOR       ?= verilator
TOP             ?= spi_master_tb
FILE_LIST       ?= spi_master.f
BUILD_DIR       ?= obj_dir
LOG_FILE        ?= simulation.log
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
FAIL_TEXT       ?= *** TEST FAILED ***
PASS_TEXT       ?= *** TEST PASSED ***

SOURCES := $(shell cat $(FILE_LIST))

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), log to $(LOG_FILE)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG_FILE)"
	@echo "make help   show this list"

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG_FILE) 2>&1
	@cat $(LOG_FILE)
	@if grep -qF '$(FAIL_TEXT)' $(LOG_FILE); then \
		echo "Simulation failed, see $(LOG_FILE)"; exit 1; fi
	@if ! grep -qF '$(PASS_TEXT)' $(LOG_FILE); then \
		echo "Simulation ended without a result, see $(LOG_FILE)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)

//--- spi_bit_timer.sv
`timescale 1ns/100ps
`default_nettype none

module spi_bit_timer (
    input  wire                               clock,
    input  wire                               reset_n,
    input  wire [spi_pkg::DIVIDER_WIDTH-1:0]  divider,
    input  wire                               run,
    output logic                              tick,
    output spi_pkg::spi_quarter_t             quarter
);
    import spi_pkg::*;

    logic [DIVIDER_WIDTH-1:0] divider_count;

    // Compare with >= so a smaller divider takes effect at once
    assign tick = (divider_count >= divider);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            divider_count <= '0;
        end else if (tick) begin
            divider_count <= '0;
        end else begin
            divider_count <= divider_count + 1'b1;
        end
    end

    ///////////////////////////////
    // Quarter within a serial bit
    ///////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            quarter <= quarter_lead_setup;
        end else if (!run) begin
            quarter <= quarter_lead_setup;
        end else if (tick) begin
            // Wraps from quarter_fall back to quarter_lead_setup
            quarter <= spi_quarter_t'(quarter + 2'd1);
        end
    end

    quarter_steps_on_tick: assert property (
        @(posedge clock) disable iff (!reset_n)
        $changed(quarter) |-> ($past(tick) || !$past(run))
    );

endmodule

`default_nettype wire

//--- spi_master.f
spi_pkg.sv
spi_bit_timer.sv
spi_shifter.sv
spi_sequencer.sv
spi_master.sv
spi_slave_model.sv
spi_master_tb.sv

//--- spi_master.sv
`timescale 1ns/100ps
`default_nettype none

module spi_master (
    input  wire                               clock,
    input  wire                               reset_n,
    input  wire spi_pkg::spi_request_t        request,
    input  wire spi_pkg::spi_mode_t           mode,
    input  wire [spi_pkg::DIVIDER_WIDTH-1:0]  divider,
    input  wire                               enable,
    input  wire                               master_in_slave_out,
    output wire                               serial_clock,
    output wire                               slave_select,
    output wire                               master_out_slave_in,
    output wire                               busy,
    output wire [spi_pkg::DATA_WIDTH-1:0]     read_data,
    output wire                               read_data_valid
);
    import spi_pkg::*;

    wire                 tick;
    wire                 run;
    wire spi_quarter_t   quarter;
    wire spi_shift_cmd_t cmd;
    wire spi_request_t   frame;

    spi_bit_timer spi_bit_timer_i (
        .clock   (clock),
        .reset_n (reset_n),
        .divider (divider),
        .run     (run),
        .tick    (tick),
        .quarter (quarter)
    );

    spi_sequencer spi_sequencer_i (
        .clock           (clock),
        .reset_n         (reset_n),
        .enable          (enable),
        .request         (request),
        .mode            (mode),
        .tick            (tick),
        .quarter         (quarter),
        .run             (run),
        .cmd             (cmd),
        .frame           (frame),
        .serial_clock    (serial_clock),
        .slave_select    (slave_select),
        .busy            (busy),
        .read_data_valid (read_data_valid)
    );

    spi_shifter spi_shifter_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .cmd                 (cmd),
        .frame               (frame),
        .master_in_slave_out (master_in_slave_out),
        .master_out_slave_in (master_out_slave_in),
        .read_data           (read_data)
    );

endmodule

`default_nettype wire

//--- spi_master_tb.sv
`timescale 1ns/100ps
`default_nettype none

module spi_master_tb;
    import spi_pkg::*;

    localparam int CLOCK_PERIOD    = 100;
    localparam int DRIVE_DELAY     = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int MAX_DIVIDER     = 3;
    // One write, four reads, four serial clock runs, one ignored enable
    localparam int TRANSFER_COUNT  = 10;
    localparam int TRANSFER_LIMIT  = (FRAME_WIDTH + 2) * 4 * (MAX_DIVIDER + 1);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TRANSFER_COUNT * TRANSFER_LIMIT + 1000;

    logic                     clock;
    logic                     reset_n;
    spi_request_t             request;
    spi_mode_t                mode;
    logic [DIVIDER_WIDTH-1:0] divider;
    logic                     enable;
    logic [FRAME_WIDTH-1:0]   slave_pattern;
    wire                      master_in_slave_out;
    wire                      serial_clock;
    wire                      slave_select;
    wire                      master_out_slave_in;
    wire                      busy;
    wire [DATA_WIDTH-1:0]     read_data;
    wire                      read_data_valid;
    wire [FRAME_WIDTH-1:0]    recorded_frame;
    wire [31:0]               leading_edges;

    int seed;
    int check_count = 0;
    int error_count = 0;
    int valid_before;
    int rest_before;

    // Bus monitor state
    logic                  monitor_sclk      = 1'b0;
    logic                  monitor_select    = 1'b1;
    logic                  rest_polarity     = 1'b0;
    logic                  edge_seen         = 1'b0;
    int                    half_length       = 0;
    int                    shortest_half     = 0;
    int                    longest_half      = 0;
    int                    rest_level_errors = 0;
    int                    valid_pulses      = 0;
    logic [DATA_WIDTH-1:0] valid_read_data   = '0;

    spi_master spi_master_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .request             (request),
        .mode                (mode),
        .divider             (divider),
        .enable              (enable),
        .master_in_slave_out (master_in_slave_out),
        .serial_clock        (serial_clock),
        .slave_select        (slave_select),
        .master_out_slave_in (master_out_slave_in),
        .busy                (busy),
        .read_data           (read_data),
        .read_data_valid     (read_data_valid)
    );

    spi_slave_model spi_slave_model_i (
        .clock               (clock),
        .mode                (mode),
        .pattern             (slave_pattern),
        .serial_clock        (serial_clock),
        .slave_select        (slave_select),
        .master_out_slave_in (master_out_slave_in),
        .master_in_slave_out (master_in_slave_out),
        .recorded            (recorded_frame),
        .leading_edges       (leading_edges)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d clock cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ///////////////////////////////
    // Bus monitor
    ///////////////////////////////

    always @(negedge clock) begin
        if (reset_n) begin
            if (busy) begin
                rest_polarity = mode.clock_polarity;
            end
            if (slave_select && serial_clock != rest_polarity) begin
                rest_level_errors++;
            end
            if (monitor_select && !slave_select) begin
                edge_seen     = 1'b0;
                shortest_half = 32'h7fff_ffff;
                longest_half  = 0;
            end
            half_length++;
            // First edge of a frame has no full phase before it
            if (!slave_select && serial_clock != monitor_sclk) begin
                if (edge_seen) begin
                    if (half_length < shortest_half) begin
                        shortest_half = half_length;
                    end
                    if (half_length > longest_half) begin
                        longest_half = half_length;
                    end
                end
                edge_seen   = 1'b1;
                half_length = 0;
            end
            if (read_data_valid) begin
                valid_pulses++;
                valid_read_data = read_data;
            end
        end
        monitor_sclk   = serial_clock;
        monitor_select = slave_select;
    end

    ///////////////////////////////
    // Helpers
    ///////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-24s done, %0d errors", name, error_count - errors_before);
    endtask

    task automatic random_request(output spi_request_t req, input spi_op_t op);
        logic [31:0] word;
        word           = $random(seed);
        req.address    = word[ADDRESS_WIDTH-1:0];
        req.read_write = op;
        req.data       = word[31:32-DATA_WIDTH];
    endtask

    task automatic start_transfer(input spi_request_t req, input spi_mode_t spi_mode,
                                  input logic [DIVIDER_WIDTH-1:0] div,
                                  input logic [FRAME_WIDTH-1:0] pattern);
        request       = req;
        mode          = spi_mode;
        divider       = div;
        slave_pattern = pattern;
        valid_before  = valid_pulses;
        rest_before   = rest_level_errors;
        enable        = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        enable        = 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (busy && cycles < TRANSFER_LIMIT) begin
            @(posedge clock);
            #DRIVE_DELAY;
            cycles++;
        end
        if (busy) begin
            error_count++;
            $display("Transfer still busy after %0d clock cycles", cycles);
        end
    endtask

    task automatic check_transfer(input logic [FRAME_WIDTH-1:0] expected_frame,
                                  input logic [FRAME_WIDTH-1:0] pattern,
                                  input logic [DIVIDER_WIDTH-1:0] div);
        int half_period;
        half_period = 2 * (int'(div) + 1);
        check_value("slave_select", 32'(slave_select), 32'd1);
        check_value("busy", 32'(busy), 32'd0);
        check_value("slave MOSI frame", recorded_frame, expected_frame);
        check_value("serial_clock leading edges", leading_edges, FRAME_WIDTH);
        check_value("read_data_valid pulses", valid_pulses - valid_before, 32'd1);
        check_value("read_data", 32'(valid_read_data), 32'(pattern[DATA_WIDTH-1:0]));
        check_value("serial_clock shortest half", shortest_half, half_period);
        check_value("serial_clock longest half", longest_half, half_period);
        check_value("serial_clock rest errors", rest_level_errors - rest_before, 32'd0);
    endtask

    task automatic run_transfer(input spi_request_t req, input spi_mode_t spi_mode,
                                input logic [DIVIDER_WIDTH-1:0] div);
        logic [FRAME_WIDTH-1:0] pattern;
        pattern = $random(seed);
        start_transfer(req, spi_mode, div, pattern);
        wait_for_done();
        check_transfer(req, pattern, div);
    endtask

    ///////////////////////////////
    // Directed tests
    ///////////////////////////////

    task automatic check_reset_values();
        int errors_before;
        errors_before = error_count;
        check_value("busy", 32'(busy), 32'd0);
        check_value("slave_select", 32'(slave_select), 32'd1);
        check_value("serial_clock", 32'(serial_clock), 32'd0);
        check_value("read_data_valid", 32'(read_data_valid), 32'd0);
        report_test("reset values", errors_before);
    endtask

    task automatic write_in_mode_0();
        int           errors_before;
        spi_request_t req;
        errors_before = error_count;
        random_request(req, op_write);
        run_transfer(req, spi_mode_t'(2'b00), 16'd1);
        report_test("write in mode 0", errors_before);
    endtask

    task automatic read_in_all_modes();
        int           errors_before;
        spi_request_t req;
        errors_before = error_count;
        for (int index = 0; index < 4; index++) begin
            random_request(req, op_read);
            run_transfer(req, spi_mode_t'(index[1:0]), 16'd1);
        end
        report_test("read in all modes", errors_before);
    endtask

    task automatic sweep_serial_clock();
        int                       errors_before;
        spi_request_t             req;
        logic [DIVIDER_WIDTH-1:0] div;
        errors_before = error_count;
        for (int index = 0; index < 4; index++) begin
            div = index[1] ? 16'd3 : 16'd0;
            random_request(req, op_write);
            // Phase follows polarity here
            run_transfer(req, spi_mode_t'({index[0], index[0]}), div);
        end
        report_test("serial clock timing", errors_before);
    endtask

    task automatic ignore_busy_enable();
        int                     errors_before;
        spi_request_t           first;
        spi_request_t           second;
        logic [FRAME_WIDTH-1:0] pattern;
        errors_before = error_count;
        random_request(first, op_read);
        random_request(second, op_write);
        pattern = $random(seed);
        start_transfer(first, spi_mode_t'(2'b10), 16'd2, pattern);
        repeat (40) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        request = second;
        enable  = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        enable  = 1'b0;
        wait_for_done();
        check_transfer(first, pattern, 16'd2);
        report_test("enable while busy", errors_before);
    endtask

    initial begin
        seed          = 32'ha087d87e;
        reset_n       = 1'b0;
        enable        = 1'b0;
        request       = '0;
        mode          = '0;
        divider       = '0;
        slave_pattern = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset_n = 1'b1;

        check_reset_values();
        write_in_mode_0();
        read_in_all_modes();
        sweep_serial_clock();
        ignore_busy_enable();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

    ///////////////////////////////
    // Frame geometry
    ///////////////////////////////

    localparam int ADDRESS_WIDTH   = 15;
    localparam int DATA_WIDTH      = 16;
    // Address, read/write flag, data
    localparam int FRAME_WIDTH     = ADDRESS_WIDTH + 1 + DATA_WIDTH;
    localparam int DIVIDER_WIDTH   = 16;
    localparam int BIT_COUNT_WIDTH = $clog2(FRAME_WIDTH + 1);

    ///////////////////////////////
    // Types
    ///////////////////////////////

    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } spi_op_t;

    // Packed order is the order on the wire
    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] address;
        spi_op_t                  read_write;
        logic [DATA_WIDTH-1:0]    data;
    } spi_request_t;

    typedef struct packed {
        logic clock_phase;
        logic clock_polarity;
    } spi_mode_t;

    // One serial bit is four divider ticks
    typedef enum logic [1:0] {
        quarter_lead_setup,
        quarter_rise,
        quarter_mid,
        quarter_fall
    } spi_quarter_t;

    typedef enum logic [2:0] {
        st_idle,
        st_select,
        st_address,
        st_data,
        st_stop
    } spi_state_t;

    // Single-cycle strobes to the shifter
    typedef struct packed {
        logic load;
        logic preshift;
        logic shift;
        logic sample;
        logic finish;
    } spi_shift_cmd_t;

endpackage

`default_nettype wire

//--- spi_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module spi_sequencer (
    input  wire                             clock,
    input  wire                             reset_n,
    input  wire                             enable,
    input  wire spi_pkg::spi_request_t      request,
    input  wire spi_pkg::spi_mode_t         mode,
    input  wire                             tick,
    input  wire spi_pkg::spi_quarter_t      quarter,
    output logic                            run,
    output spi_pkg::spi_shift_cmd_t         cmd,
    output spi_pkg::spi_request_t           frame,
    output logic                            serial_clock,
    output logic                            slave_select,
    output logic                            busy,
    output logic                            read_data_valid
);
    import spi_pkg::*;

    spi_state_t                 state;
    spi_mode_t                  mode_q;
    logic [BIT_COUNT_WIDTH-1:0] bit_count;
    logic                       sclk_level;
    logic                       accept;
    logic                       in_frame;
    logic                       last_bit;

    assign accept   = (state == st_idle) && enable;
    assign in_frame = (state == st_address) || (state == st_data);
    assign run      = in_frame || (state == st_stop);

    // Address field carries the read/write flag as its last bit
    assign last_bit = (state == st_address) ?
                      (bit_count == BIT_COUNT_WIDTH'(ADDRESS_WIDTH)) :
                      (bit_count == BIT_COUNT_WIDTH'(DATA_WIDTH - 1));

    assign serial_clock = sclk_level ^ mode_q.clock_polarity;

    ///////////////////////////////
    // Shifter strobes
    ///////////////////////////////

    always_comb begin
        cmd = '0;
        if (tick) begin
            cmd.load     = (state == st_select);
            cmd.preshift = (state == st_select) && !mode_q.clock_phase;
            if (mode_q.clock_phase) begin
                cmd.shift  = in_frame && (quarter == quarter_rise);
                // Last bit is picked up in the first quarter of st_stop
                cmd.sample = run && (quarter == quarter_lead_setup);
            end else begin
                cmd.shift  = in_frame && (quarter == quarter_fall);
                cmd.sample = in_frame && (quarter == quarter_mid);
            end
            cmd.finish   = (state == st_stop) && (quarter == quarter_rise);
        end
    end

    ///////////////////////////////
    // Transfer FSM
    ///////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state           <= st_idle;
            mode_q          <= '0;
            bit_count       <= '0;
            sclk_level      <= 1'b0;
            slave_select    <= 1'b1;
            busy            <= 1'b0;
            read_data_valid <= 1'b0;
        end else begin
            read_data_valid <= 1'b0;

            case (state)
                st_idle: begin
                    if (accept) begin
                        mode_q <= mode;
                        busy   <= 1'b1;
                        state  <= st_select;
                    end
                end
                st_select: begin
                    if (tick) begin
                        slave_select <= 1'b0;
                        state        <= st_address;
                    end
                end
                st_address, st_data: begin
                    if (tick && quarter == quarter_rise) begin
                        sclk_level <= 1'b1;
                    end
                    if (tick && quarter == quarter_fall) begin
                        sclk_level <= 1'b0;
                        if (last_bit) begin
                            bit_count <= '0;
                            state     <= (state == st_address) ? st_data : st_stop;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (tick && quarter == quarter_rise) begin
                        slave_select    <= 1'b1;
                        read_data_valid <= 1'b1;
                    end
                    if (tick && quarter == quarter_fall) begin
                        busy  <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Request held for the whole transfer
    always_ff @(posedge clock) begin
        if (accept) begin
            frame <= request;
        end
    end

    select_inside_busy: assert property (
        @(posedge clock) disable iff (!reset_n)
        !slave_select |-> busy
    );

    valid_only_in_stop: assert property (
        @(posedge clock) disable iff (!reset_n)
        read_data_valid |-> (state == st_stop)
    );

endmodule

`default_nettype wire

//--- spi_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module spi_shifter (
    input  wire                             clock,
    input  wire                             reset_n,
    input  wire spi_pkg::spi_shift_cmd_t    cmd,
    input  wire spi_pkg::spi_request_t      frame,
    input  wire                             master_in_slave_out,
    output logic                            master_out_slave_in,
    output logic [spi_pkg::DATA_WIDTH-1:0]  read_data
);
    import spi_pkg::*;

    logic [FRAME_WIDTH-1:0] tx_shift;
    logic [DATA_WIDTH-1:0]  rx_shift;

    ///////////////////////////////
    // Shift registers
    ///////////////////////////////

    always_ff @(posedge clock) begin
        if (cmd.load) begin
            // Phase 0 puts the MSB out at load, so it leaves the register now
            if (cmd.preshift) begin
                tx_shift <= {frame[FRAME_WIDTH-2:0], 1'b0};
            end else begin
                tx_shift <= frame;
            end
        end else if (cmd.shift) begin
            tx_shift <= {tx_shift[FRAME_WIDTH-2:0], 1'b0};
        end

        // Only the last DATA_WIDTH samples are kept
        if (cmd.sample) begin
            rx_shift <= {rx_shift[DATA_WIDTH-2:0], master_in_slave_out};
        end
    end

    ///////////////////////////////
    // Serial output and read data
    ///////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            master_out_slave_in <= 1'b0;
            read_data           <= '0;
        end else begin
            if (cmd.finish) begin
                master_out_slave_in <= 1'b0;
                read_data           <= rx_shift;
            end else if (cmd.load && cmd.preshift) begin
                master_out_slave_in <= frame[FRAME_WIDTH-1];
            end else if (cmd.shift) begin
                master_out_slave_in <= tx_shift[FRAME_WIDTH-1];
            end
        end
    end

    // Sequencer never loads a frame on a sampling quarter
    no_load_during_sample: assert property (
        @(posedge clock) disable iff (!reset_n)
        !(cmd.load && cmd.sample)
    );

endmodule

`default_nettype wire

//--- spi_slave_model.sv
`timescale 1ns/100ps
`default_nettype none

module spi_slave_model (
    input  wire                             clock,
    input  wire spi_pkg::spi_mode_t         mode,
    input  wire [spi_pkg::FRAME_WIDTH-1:0]  pattern,
    input  wire                             serial_clock,
    input  wire                             slave_select,
    input  wire                             master_out_slave_in,
    output wire                             master_in_slave_out,
    output wire [spi_pkg::FRAME_WIDTH-1:0]  recorded,
    output wire [31:0]                      leading_edges
);
    import spi_pkg::*;

    localparam int DRIVE_DELAY = 10;

    logic [FRAME_WIDTH-1:0] tx_pattern  = '0;
    logic [FRAME_WIDTH-1:0] rx_frame    = '0;
    logic [31:0]            edge_count  = '0;
    logic                   miso_bit    = 1'b0;
    logic                   last_sclk   = 1'b0;
    logic                   last_select = 1'b1;
    logic                   leading;
    logic                   trailing;
    logic                   sample_edge;
    logic                   change_edge;

    assign master_in_slave_out = miso_bit;
    assign recorded            = rx_frame;
    assign leading_edges       = edge_count;

    // Edges found against the level one clock earlier
    always @(posedge clock) begin
        #DRIVE_DELAY;
        leading     = (serial_clock != last_sclk) && (serial_clock != mode.clock_polarity);
        trailing    = (serial_clock != last_sclk) && (serial_clock == mode.clock_polarity);
        sample_edge = mode.clock_phase ? trailing : leading;
        change_edge = mode.clock_phase ? leading : trailing;

        if (last_select && !slave_select) begin
            rx_frame   = '0;
            edge_count = '0;
            tx_pattern = pattern;
            // Phase 0 has the first bit out before any edge
            if (!mode.clock_phase) begin
                miso_bit   = tx_pattern[FRAME_WIDTH-1];
                tx_pattern = tx_pattern << 1;
            end
        end else if (!slave_select) begin
            if (leading) begin
                edge_count = edge_count + 32'd1;
            end
            if (sample_edge) begin
                rx_frame = {rx_frame[FRAME_WIDTH-2:0], master_out_slave_in};
            end
            if (change_edge) begin
                miso_bit   = tx_pattern[FRAME_WIDTH-1];
                tx_pattern = tx_pattern << 1;
            end
        end

        last_sclk   = serial_clock;
        last_select = slave_select;
    end

endmodule

`default_nettype wire
